// ==== decode_pkg.sv ====
package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam word_t INST_NOP   = 32'h0000_0013;  // addi x0, x0, 0
    localparam word_t INST_ECALL = 32'h0000_0073;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [4:0] {
        EXE_ADD, EXE_SUB, EXE_AND, EXE_OR, EXE_XOR,
        EXE_SLL, EXE_SRL, EXE_SRA, EXE_SLT, EXE_SLTU,
        EXE_JALR,
        EXE_BEQ, EXE_BNE, EXE_BLT, EXE_BGE, EXE_BLTU, EXE_BGEU
    } exe_fun_t;

    typedef enum logic [1:0] {
        OP1_NONE, OP1_RS1, OP1_PC
    } op1_sel_t;

    typedef enum logic [2:0] {
        OP2_NONE, OP2_RS2, OP2_IMM_I, OP2_IMM_S, OP2_IMM_J, OP2_IMM_U
    } op2_sel_t;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW
    } mem_fun_t;

    typedef enum logic [2:0] {
        WB_NONE, WB_ALU, WB_MEM_B, WB_MEM_BU, WB_MEM_H, WB_MEM_HU, WB_MEM_W, WB_PC
    } wb_sel_t;

    typedef struct packed {
        exe_fun_t exe_fun;
        op1_sel_t op1_sel;
        op2_sel_t op2_sel;
        mem_fun_t mem_fun;
        logic     rf_wen;
        wb_sel_t  wb_sel;
        logic     jmp;
        logic     ecall;
    } ctrl_t;

    typedef struct packed {
        word_t i;
        word_t s;
        word_t b;
        word_t j;
        word_t u;  // already shifted up by 12
    } imm_t;

    typedef struct packed {
        logic      rf_wen;
        reg_addr_t addr;
    } dest_t;

    typedef struct packed {
        word_t     pc;
        word_t     op1;
        word_t     op2;
        word_t     rs2_data;
        word_t     imm;  // branch or jump offset
        reg_addr_t wb_addr;
        ctrl_t     ctrl;
    } issue_t;

    // also the bubble and the unknown-encoding decode
    localparam ctrl_t CTRL_NONE = '{
        exe_fun: EXE_ADD,
        op1_sel: OP1_NONE,
        op2_sel: OP2_NONE,
        mem_fun: MEM_NONE,
        rf_wen:  1'b0,
        wb_sel:  WB_NONE,
        jmp:     1'b0,
        ecall:   1'b0
    };

endpackage

// ==== inst_hold.sv ====
module inst_hold #(
    parameter decode_pkg::word_t NOP_PC = '0
) (
    input  logic              clk,
    input  logic              reset,
    input  decode_pkg::word_t inst,
    input  decode_pkg::word_t pc,
    input  logic              flush,
    input  logic              mem_stall,
    output decode_pkg::word_t cur_inst,
    output decode_pkg::word_t cur_pc
);

    import decode_pkg::*;

    word_t save_inst;
    word_t save_pc;

    always_comb begin
        if (flush) begin
            cur_inst = INST_NOP;
            cur_pc   = NOP_PC;
        end else if (mem_stall) begin
            cur_inst = save_inst;  // replay held instruction
            cur_pc   = save_pc;
        end else begin
            cur_inst = inst;
            cur_pc   = pc;
        end
    end

    // a flush already shows up as nop on cur_inst
    always_ff @(posedge clk) begin
        if (reset) begin
            save_inst <= INST_NOP;
            save_pc   <= NOP_PC;
        end else begin
            save_inst <= cur_inst;
            save_pc   <= cur_pc;
        end
    end

endmodule

// ==== control_decoder.sv ====
module control_decoder (
    input  decode_pkg::word_t     cur_inst,
    output decode_pkg::ctrl_t     ctrl,
    output decode_pkg::imm_t      imm,
    output decode_pkg::reg_addr_t rs1,
    output decode_pkg::reg_addr_t rs2,
    output decode_pkg::reg_addr_t rd
);

    import decode_pkg::*;

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    function automatic ctrl_t alu_row(input exe_fun_t f, input op2_sel_t src);
        ctrl_t c;
        c         = CTRL_NONE;
        c.exe_fun = f;
        c.op1_sel = OP1_RS1;
        c.op2_sel = src;
        c.rf_wen  = 1'b1;
        c.wb_sel  = WB_ALU;
        return c;
    endfunction

    function automatic ctrl_t load_row(input mem_fun_t m, input wb_sel_t s);
        ctrl_t c;
        c         = alu_row(EXE_ADD, OP2_IMM_I);  // address = rs1 + imm
        c.mem_fun = m;
        c.wb_sel  = s;
        return c;
    endfunction

    function automatic ctrl_t store_row(input mem_fun_t m);
        ctrl_t c;
        c         = CTRL_NONE;
        c.op1_sel = OP1_RS1;
        c.op2_sel = OP2_IMM_S;
        c.mem_fun = m;
        return c;
    endfunction

    function automatic ctrl_t branch_row(input exe_fun_t f);
        ctrl_t c;
        c         = CTRL_NONE;
        c.exe_fun = f;
        c.op1_sel = OP1_RS1;
        c.op2_sel = OP2_RS2;
        return c;
    endfunction

    assign opcode = opcode_t'(cur_inst[6:0]);
    assign funct3 = cur_inst[14:12];
    assign funct7 = cur_inst[31:25];
    assign rs1    = cur_inst[19:15];
    assign rs2    = cur_inst[24:20];
    assign rd     = cur_inst[11:7];

    assign imm.i = {{20{cur_inst[31]}}, cur_inst[31:20]};
    assign imm.s = {{20{cur_inst[31]}}, cur_inst[31:25], cur_inst[11:7]};
    assign imm.b = {{19{cur_inst[31]}}, cur_inst[31], cur_inst[7], cur_inst[30:25],
                    cur_inst[11:8], 1'b0};
    assign imm.j = {{11{cur_inst[31]}}, cur_inst[31], cur_inst[19:12], cur_inst[20],
                    cur_inst[30:21], 1'b0};
    assign imm.u = {cur_inst[31:12], 12'b0};

    always_comb begin
        ctrl = CTRL_NONE;  // unknown encodings stay here
        case (opcode)
            OPC_LOAD: begin
                case (funct3)
                    3'b000:  ctrl = load_row(MEM_LB, WB_MEM_B);
                    3'b001:  ctrl = load_row(MEM_LH, WB_MEM_H);
                    3'b010:  ctrl = load_row(MEM_LW, WB_MEM_W);
                    3'b100:  ctrl = load_row(MEM_LBU, WB_MEM_BU);
                    3'b101:  ctrl = load_row(MEM_LHU, WB_MEM_HU);
                    default: ctrl = CTRL_NONE;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    3'b000:  ctrl = store_row(MEM_SB);
                    3'b001:  ctrl = store_row(MEM_SH);
                    3'b010:  ctrl = store_row(MEM_SW);
                    default: ctrl = CTRL_NONE;
                endcase
            end
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: ctrl = alu_row(EXE_ADD, OP2_RS2);
                    {7'h20, 3'b000}: ctrl = alu_row(EXE_SUB, OP2_RS2);
                    {7'h00, 3'b001}: ctrl = alu_row(EXE_SLL, OP2_RS2);
                    {7'h00, 3'b010}: ctrl = alu_row(EXE_SLT, OP2_RS2);
                    {7'h00, 3'b011}: ctrl = alu_row(EXE_SLTU, OP2_RS2);
                    {7'h00, 3'b100}: ctrl = alu_row(EXE_XOR, OP2_RS2);
                    {7'h00, 3'b101}: ctrl = alu_row(EXE_SRL, OP2_RS2);
                    {7'h20, 3'b101}: ctrl = alu_row(EXE_SRA, OP2_RS2);
                    {7'h00, 3'b110}: ctrl = alu_row(EXE_OR, OP2_RS2);
                    {7'h00, 3'b111}: ctrl = alu_row(EXE_AND, OP2_RS2);
                    default:         ctrl = CTRL_NONE;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'b000: ctrl = alu_row(EXE_ADD, OP2_IMM_I);
                    3'b010: ctrl = alu_row(EXE_SLT, OP2_IMM_I);
                    3'b011: ctrl = alu_row(EXE_SLTU, OP2_IMM_I);
                    3'b100: ctrl = alu_row(EXE_XOR, OP2_IMM_I);
                    3'b110: ctrl = alu_row(EXE_OR, OP2_IMM_I);
                    3'b111: ctrl = alu_row(EXE_AND, OP2_IMM_I);
                    3'b001: if (funct7 == 7'h00) ctrl = alu_row(EXE_SLL, OP2_IMM_I);
                    3'b101: begin
                        if (funct7 == 7'h00) ctrl = alu_row(EXE_SRL, OP2_IMM_I);
                        else if (funct7 == 7'h20) ctrl = alu_row(EXE_SRA, OP2_IMM_I);
                    end
                    default: ctrl = CTRL_NONE;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'b000:  ctrl = branch_row(EXE_BEQ);
                    3'b001:  ctrl = branch_row(EXE_BNE);
                    3'b100:  ctrl = branch_row(EXE_BLT);
                    3'b101:  ctrl = branch_row(EXE_BGE);
                    3'b110:  ctrl = branch_row(EXE_BLTU);
                    3'b111:  ctrl = branch_row(EXE_BGEU);
                    default: ctrl = CTRL_NONE;
                endcase
            end
            OPC_JAL: begin
                ctrl         = alu_row(EXE_ADD, OP2_IMM_J);
                ctrl.op1_sel = OP1_PC;  // target = pc + imm_j
                ctrl.wb_sel  = WB_PC;
                ctrl.jmp     = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    ctrl        = alu_row(EXE_JALR, OP2_IMM_I);
                    ctrl.wb_sel = WB_PC;
                    ctrl.jmp    = 1'b1;
                end
            end
            OPC_LUI: begin
                ctrl         = alu_row(EXE_ADD, OP2_IMM_U);
                ctrl.op1_sel = OP1_NONE;  // zero + imm_u
            end
            OPC_AUIPC: begin
                ctrl         = alu_row(EXE_ADD, OP2_IMM_U);
                ctrl.op1_sel = OP1_PC;
            end
            OPC_SYSTEM: begin
                if (cur_inst == INST_ECALL) ctrl.ecall = 1'b1;
            end
            default: ctrl = CTRL_NONE;
        endcase
    end

endmodule

// ==== hazard_detect.sv ====
module hazard_detect (
    input  decode_pkg::ctrl_t     ctrl,
    input  decode_pkg::reg_addr_t rs1,
    input  decode_pkg::reg_addr_t rs2,
    input  decode_pkg::dest_t     exe_dest,
    input  decode_pkg::dest_t     mem_dest,
    input  decode_pkg::dest_t     wb_dest,
    input  logic                  flush,
    output logic                  stall
);

    import decode_pkg::*;

    logic rs1_used;
    logic rs2_used;

    // one in-flight destination against the sources this instruction reads
    function automatic logic dest_hit(
        input dest_t     d,
        input reg_addr_t src1,
        input logic      use1,
        input reg_addr_t src2,
        input logic      use2
    );
        logic live;
        live = d.rf_wen && (d.addr != '0);
        return live && ((use1 && d.addr == src1) || (use2 && d.addr == src2));
    endfunction

    assign rs1_used = (ctrl.op1_sel == OP1_RS1);

    // stores read rs2 as data even though op2 is the s immediate
    assign rs2_used = (ctrl.op2_sel == OP2_RS2) ||
                      (ctrl.mem_fun inside {MEM_SB, MEM_SH, MEM_SW});

    always_comb begin
        stall = 1'b0;
        if (!flush) begin
            stall = dest_hit(exe_dest, rs1, rs1_used, rs2, rs2_used) ||
                    dest_hit(mem_dest, rs1, rs1_used, rs2, rs2_used) ||
                    dest_hit(wb_dest, rs1, rs1_used, rs2, rs2_used);
        end
    end

endmodule

// ==== register_file.sv ====
module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  decode_pkg::reg_addr_t rs1,
    input  decode_pkg::reg_addr_t rs2,
    input  logic                  wr_en,
    input  decode_pkg::reg_addr_t wr_addr,
    input  decode_pkg::word_t     wr_data,
    output decode_pkg::word_t     rs1_data,
    output decode_pkg::word_t     rs2_data
);

    import decode_pkg::*;

    localparam int NUM_REGS = 2 ** REG_ADDR_W;

    word_t regs [1:NUM_REGS-1];  // x0 has no storage

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // no bypass of a same-cycle write
    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== operand_issue.sv ====
module operand_issue #(
    parameter decode_pkg::word_t NOP_PC = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  decode_pkg::word_t     cur_pc,
    input  decode_pkg::ctrl_t     ctrl,
    input  decode_pkg::imm_t      imm,
    input  decode_pkg::reg_addr_t rd,
    input  decode_pkg::word_t     rs1_data,
    input  decode_pkg::word_t     rs2_data,
    output decode_pkg::issue_t    issue
);

    import decode_pkg::*;

    word_t op1;
    word_t op2;
    word_t target_imm;
    logic  is_branch;

    always_comb begin
        case (ctrl.op1_sel)
            OP1_RS1: op1 = rs1_data;
            OP1_PC:  op1 = cur_pc;
            default: op1 = '0;
        endcase
    end

    always_comb begin
        case (ctrl.op2_sel)
            OP2_RS2:   op2 = rs2_data;
            OP2_IMM_I: op2 = imm.i;
            OP2_IMM_S: op2 = imm.s;
            OP2_IMM_J: op2 = imm.j;
            OP2_IMM_U: op2 = imm.u;
            default:   op2 = '0;
        endcase
    end

    assign is_branch = ctrl.exe_fun inside {EXE_BEQ, EXE_BNE, EXE_BLT, EXE_BGE,
                                            EXE_BLTU, EXE_BGEU};

    // branch offset for branches, jalr offset otherwise
    assign target_imm = is_branch ? imm.b : imm.i;

    always_ff @(posedge clk) begin
        issue.op1      <= op1;
        issue.op2      <= op2;
        issue.rs2_data <= rs2_data;  // store data
        issue.imm      <= target_imm;
        issue.wb_addr  <= rd;
        if (reset || stall) begin
            issue.ctrl <= CTRL_NONE;  // bubble
            issue.pc   <= NOP_PC;
        end else begin
            issue.ctrl <= ctrl;
            issue.pc   <= cur_pc;
        end
    end

endmodule

// ==== decode_stage.sv ====
module decode_stage #(
    parameter decode_pkg::word_t NOP_PC = '0
) (
    input  logic                  clk,
    input  logic                  reset,
    input  decode_pkg::word_t     inst,
    input  decode_pkg::word_t     pc,
    input  logic                  flush,
    input  logic                  mem_stall,
    input  decode_pkg::dest_t     exe_dest,
    input  decode_pkg::dest_t     mem_dest,
    input  decode_pkg::dest_t     wb_dest,
    input  logic                  wr_en,
    input  decode_pkg::reg_addr_t wr_addr,
    input  decode_pkg::word_t     wr_data,
    output logic                  stall,
    output decode_pkg::issue_t    issue
);

    import decode_pkg::*;

    word_t     cur_inst;
    word_t     cur_pc;
    ctrl_t     ctrl;
    imm_t      imm;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t     rs1_data;
    word_t     rs2_data;

    inst_hold #(
        .NOP_PC (NOP_PC)
    ) i_inst_hold (
        .clk       (clk),
        .reset     (reset),
        .inst      (inst),
        .pc        (pc),
        .flush     (flush),
        .mem_stall (mem_stall),
        .cur_inst  (cur_inst),
        .cur_pc    (cur_pc)
    );

    control_decoder i_control_decoder (
        .cur_inst (cur_inst),
        .ctrl     (ctrl),
        .imm      (imm),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd)
    );

    hazard_detect i_hazard_detect (
        .ctrl     (ctrl),
        .rs1      (rs1),
        .rs2      (rs2),
        .exe_dest (exe_dest),
        .mem_dest (mem_dest),
        .wb_dest  (wb_dest),
        .flush    (flush),
        .stall    (stall)
    );

    register_file i_register_file (
        .clk      (clk),
        .reset    (reset),
        .rs1      (rs1),
        .rs2      (rs2),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    operand_issue #(
        .NOP_PC (NOP_PC)
    ) i_operand_issue (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .cur_pc   (cur_pc),
        .ctrl     (ctrl),
        .imm      (imm),
        .rd       (rd),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .issue    (issue)
    );

endmodule

// ==== decode_checker.sv ====
module decode_checker (
    input  logic               clk,
    input  logic               stall,
    input  decode_pkg::issue_t issue,
    input  logic               stall_check,
    input  logic               exp_stall,
    input  logic               issue_check,
    input  logic               bubble,
    input  logic               imm_check,
    input  decode_pkg::issue_t exp_issue,
    output int                 checks,
    output int                 errors
);

    timeunit 1ns;
    timeprecision 100ps;

    import decode_pkg::*;

    int check_count = 0;
    int error_count = 0;

    assign checks = check_count;
    assign errors = error_count;

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got) begin
            $display("Mismatch %s exp %h got %h", name, exp, got);
            error_count++;
        end
    endtask

    // inputs change on the falling edge, so look a little later
    always @(negedge clk) begin
        #3;
        if (stall_check) begin
            compare("stall", 32'(exp_stall), 32'(stall));
        end
        if (issue_check) begin
            compare("issue.pc", exp_issue.pc, issue.pc);
            if (bubble) begin  // data fields are don't care
                compare("issue.ctrl.rf_wen", 32'(exp_issue.ctrl.rf_wen), 32'(issue.ctrl.rf_wen));
                compare("issue.ctrl.mem_fun", 32'(exp_issue.ctrl.mem_fun),
                        32'(issue.ctrl.mem_fun));
                compare("issue.ctrl.wb_sel", 32'(exp_issue.ctrl.wb_sel), 32'(issue.ctrl.wb_sel));
                compare("issue.ctrl.jmp", 32'(exp_issue.ctrl.jmp), 32'(issue.ctrl.jmp));
                compare("issue.ctrl.ecall", 32'(exp_issue.ctrl.ecall), 32'(issue.ctrl.ecall));
            end else begin
                compare("issue.ctrl", 32'(exp_issue.ctrl), 32'(issue.ctrl));
                compare("issue.op1", exp_issue.op1, issue.op1);
                compare("issue.op2", exp_issue.op2, issue.op2);
                compare("issue.rs2_data", exp_issue.rs2_data, issue.rs2_data);
                compare("issue.wb_addr", 32'(exp_issue.wb_addr), 32'(issue.wb_addr));
                if (imm_check) begin
                    compare("issue.imm", exp_issue.imm, issue.imm);
                end
            end
        end
        if (stall_check || issue_check) begin
            check_count++;
        end
    end

endmodule

// ==== tb_decode_stage.sv ====
module tb_decode_stage;

    timeunit 1ns;
    timeprecision 100ps;

    import decode_pkg::*;

    localparam word_t NOP_PC     = 32'h0000_0ffc;
    localparam int    MAX_ROWS   = 40;
    localparam int    WAIT_LIMIT = 50;

    typedef struct packed {
        word_t  inst;
        word_t  pc;
        logic   flush;
        logic   mem_stall;
        dest_t  exe_dest;
        dest_t  mem_dest;
        dest_t  wb_dest;
        logic   stall;
        logic   imm_check;
        issue_t exp;
    } row_t;

    logic      clk = 1'b0;
    logic      reset;
    word_t     inst;
    word_t     pc;
    logic      flush;
    logic      mem_stall;
    dest_t     exe_dest;
    dest_t     mem_dest;
    dest_t     wb_dest;
    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;
    logic      stall;
    issue_t    issue;

    logic   stall_check;
    logic   exp_stall;
    logic   issue_check;
    logic   bubble;
    logic   imm_check;
    issue_t exp_issue;
    int     checks;
    int     errors;

    word_t mirror [0:31];
    row_t  rows [MAX_ROWS];
    int    num_rows = 0;
    word_t prev_inst = INST_NOP;  // what inst_hold saved last
    word_t prev_pc = '0;
    int    expected_checks = 0;
    int    timeouts = 0;
    int    cycles;

    decode_stage #(.NOP_PC(NOP_PC)) i_decode_stage (
        .clk(clk), .reset(reset), .inst(inst), .pc(pc), .flush(flush),
        .mem_stall(mem_stall), .exe_dest(exe_dest), .mem_dest(mem_dest),
        .wb_dest(wb_dest), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .stall(stall), .issue(issue)
    );

    decode_checker i_decode_checker (
        .clk(clk), .stall(stall), .issue(issue), .stall_check(stall_check),
        .exp_stall(exp_stall), .issue_check(issue_check), .bubble(bubble),
        .imm_check(imm_check), .exp_issue(exp_issue), .checks(checks), .errors(errors)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    function automatic ctrl_t ctl(input exe_fun_t e, input op1_sel_t a, input op2_sel_t b,
                                  input mem_fun_t m, input logic w, input wb_sel_t s,
                                  input logic j, input logic ec);
        ctrl_t c;
        c = '{e, a, b, m, w, s, j, ec};
        return c;
    endfunction

    function automatic dest_t dst(input logic en, input reg_addr_t a);
        dest_t d;
        d.rf_wen = en;
        d.addr   = a;
        return d;
    endfunction

    // iv is the immediate the instruction carries, already extended
    task automatic add_row(input word_t in, input logic fl, input logic ms, input dest_t ed,
                           input dest_t md, input dest_t wd, input logic st, input word_t iv,
                           input ctrl_t c);
        row_t  r;
        word_t ei;
        word_t ep;
        r      = '0;
        r.inst = in;
        r.pc   = 32'h100 + 4 * num_rows;
        if (fl) begin
            ei = INST_NOP;
            ep = NOP_PC;
        end else if (ms) begin
            ei = prev_inst;  // replay of the saved copy
            ep = prev_pc;
        end else begin
            ei = in;
            ep = r.pc;
        end
        prev_inst = ei;
        prev_pc   = ep;
        {r.flush, r.mem_stall, r.exe_dest, r.mem_dest, r.wb_dest, r.stall} =
            {fl, ms, ed, md, wd, st};
        r.exp.ctrl     = c;
        r.exp.pc       = st ? NOP_PC : ep;
        r.exp.op1      = (c.op1_sel == OP1_RS1) ? mirror[ei[19:15]] :
                         (c.op1_sel == OP1_PC) ? ep : '0;
        r.exp.op2      = (c.op2_sel == OP2_RS2) ? mirror[ei[24:20]] :
                         (c.op2_sel == OP2_NONE) ? '0 : iv;
        r.exp.rs2_data = mirror[ei[24:20]];
        r.exp.wb_addr  = ei[11:7];
        r.exp.imm      = iv;
        r.imm_check    = (c.exe_fun >= EXE_JALR);  // jalr and branches
        rows[num_rows] = r;
        num_rows++;
    endtask

    task automatic build_table();
        dest_t n;
        ctrl_t c_nop;
        n     = '0;
        c_nop = ctl(EXE_ADD, OP1_RS1, OP2_IMM_I, MEM_NONE, 1, WB_ALU, 0, 0);
        add_row(32'h002081B3, 0, 0, n, n, n, 0, 0,
                ctl(EXE_ADD, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h40628233, 0, 0, n, n, n, 0, 0,
                ctl(EXE_SUB, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h009473B3, 0, 0, n, n, n, 0, 0,
                ctl(EXE_AND, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h00C5E533, 0, 0, n, n, n, 0, 0,
                ctl(EXE_OR, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h00E046B3, 0, 0, n, n, n, 0, 0,
                ctl(EXE_XOR, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h011817B3, 0, 0, n, n, n, 0, 0,
                ctl(EXE_SLL, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h4149D933, 0, 0, n, n, n, 0, 0,
                ctl(EXE_SRA, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h017B3AB3, 0, 0, n, n, n, 0, 0,
                ctl(EXE_SLTU, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'hFFB08293, 0, 0, n, n, n, 0, 32'hFFFFFFFB,
                ctl(EXE_ADD, OP1_RS1, OP2_IMM_I, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h06412313, 0, 0, n, n, n, 0, 32'd100,
                ctl(EXE_SLT, OP1_RS1, OP2_IMM_I, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h4041D393, 0, 0, n, n, n, 0, 32'h404,
                ctl(EXE_SRA, OP1_RS1, OP2_IMM_I, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h7FF24413, 0, 0, n, n, n, 0, 32'h7FF,
                ctl(EXE_XOR, OP1_RS1, OP2_IMM_I, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h00812483, 0, 0, n, n, n, 0, 32'd8,
                ctl(EXE_ADD, OP1_RS1, OP2_IMM_I, MEM_LW, 1, WB_MEM_W, 0, 0));
        add_row(32'hFFF1C503, 0, 0, n, n, n, 0, 32'hFFFFFFFF,
                ctl(EXE_ADD, OP1_RS1, OP2_IMM_I, MEM_LBU, 1, WB_MEM_BU, 0, 0));
        add_row(32'h00532623, 0, 0, n, n, n, 0, 32'd12,
                ctl(EXE_ADD, OP1_RS1, OP2_IMM_S, MEM_SW, 0, WB_NONE, 0, 0));
        add_row(32'hFE741E23, 0, 0, n, n, n, 0, 32'hFFFFFFFC,
                ctl(EXE_ADD, OP1_RS1, OP2_IMM_S, MEM_SH, 0, WB_NONE, 0, 0));
        add_row(32'h123455B7, 0, 0, n, n, n, 0, 32'h12345000,
                ctl(EXE_ADD, OP1_NONE, OP2_IMM_U, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'hABCDE617, 0, 0, n, n, n, 0, 32'hABCDE000,
                ctl(EXE_ADD, OP1_PC, OP2_IMM_U, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h00208863, 0, 0, n, n, n, 0, 32'd16,
                ctl(EXE_BEQ, OP1_RS1, OP2_RS2, MEM_NONE, 0, WB_NONE, 0, 0));
        add_row(32'hFE41ECE3, 0, 0, n, n, n, 0, 32'hFFFFFFF8,
                ctl(EXE_BLTU, OP1_RS1, OP2_RS2, MEM_NONE, 0, WB_NONE, 0, 0));
        add_row(32'h001000EF, 0, 0, n, n, n, 0, 32'h800,
                ctl(EXE_ADD, OP1_PC, OP2_IMM_J, MEM_NONE, 1, WB_PC, 1, 0));
        add_row(32'h004302E7, 0, 0, n, n, n, 0, 32'd4,
                ctl(EXE_JALR, OP1_RS1, OP2_IMM_I, MEM_NONE, 1, WB_PC, 1, 0));
        add_row(32'h00000073, 0, 0, n, n, n, 0, 0,
                ctl(EXE_ADD, OP1_NONE, OP2_NONE, MEM_NONE, 0, WB_NONE, 0, 1));
        // exe hits rs1, mem hits rs2, wb hits store data
        add_row(32'h002081B3, 0, 0, dst(1, 1), n, n, 1, 0, '0);
        add_row(32'h002081B3, 0, 0, n, dst(1, 2), n, 1, 0, '0);
        add_row(32'h00532623, 0, 0, n, n, dst(1, 5), 1, 0, '0);
        add_row(32'h002081B3, 0, 0, dst(0, 1), n, n, 0, 0,
                ctl(EXE_ADD, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h002081B3, 0, 0, n, n, dst(1, 9), 0, 0,
                ctl(EXE_ADD, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h00E046B3, 0, 0, dst(1, 0), n, n, 0, 0,
                ctl(EXE_XOR, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h002081B3, 1, 0, dst(1, 1), n, n, 0, 0, c_nop);
        add_row(32'h00C5E533, 0, 0, n, n, n, 0, 0,
                ctl(EXE_OR, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h40628233, 0, 1, n, n, n, 0, 0,
                ctl(EXE_OR, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
        add_row(32'h002081B3, 0, 0, n, n, n, 0, 0,
                ctl(EXE_ADD, OP1_RS1, OP2_RS2, MEM_NONE, 1, WB_ALU, 0, 0));
    endtask

    initial begin
        {inst, pc, flush, mem_stall} = {INST_NOP, 32'h0, 1'b0, 1'b0};
        {exe_dest, mem_dest, wb_dest} = '0;
        {wr_en, wr_addr, wr_data} = '0;
        {stall_check, exp_stall, issue_check, bubble, imm_check} = '0;
        exp_issue = '0;
        reset = 1'b1;
        void'($urandom(6));
        repeat (7) @(negedge clk);
        issue_check   = 1'b1;  // reset must leave a bubble
        bubble        = 1'b1;
        exp_issue.pc  = NOP_PC;
        expected_checks++;
        @(negedge clk);
        {reset, issue_check, bubble} = '0;
        mirror[0] = '0;
        for (int r = 1; r < 32; r++) begin
            wr_en     = 1'b1;
            wr_addr   = reg_addr_t'(r);
            wr_data   = $urandom;
            mirror[r] = wr_data;
            @(negedge clk);
        end
        wr_en = 1'b0;
        build_table();
        for (int i = 0; i <= num_rows; i++) begin
            stall_check = (i < num_rows);
            if (i < num_rows) begin
                {inst, pc, flush, mem_stall} =
                    {rows[i].inst, rows[i].pc, rows[i].flush, rows[i].mem_stall};
                {exe_dest, mem_dest, wb_dest} =
                    {rows[i].exe_dest, rows[i].mem_dest, rows[i].wb_dest};
                exp_stall = rows[i].stall;
            end
            issue_check = (i > 0);
            if (i > 0) begin  // issue shows the previous row
                exp_issue = rows[i-1].exp;
                bubble    = rows[i-1].stall;
                imm_check = rows[i-1].imm_check;
            end
            expected_checks++;
            @(negedge clk);
        end
        {stall_check, issue_check} = '0;
        cycles = 0;
        while (checks < expected_checks && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (checks < expected_checks) begin
            $display("timeout: checker finished %0d of %0d checks", checks, expected_checks);
            timeouts++;
        end
        $display("errors: mismatches=%0d timeouts=%0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== project.f ====
decode_pkg.sv
inst_hold.sv
control_decoder.sv
hazard_detect.sv
register_file.sv
operand_issue.sv
decode_stage.sv
decode_checker.sv
tb_decode_stage.sv
